// ==== access_state_ctrl.sv ====
`timescale 1ns/1ns

module access_state_ctrl
    import regbank_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wen,
    input  logic [REG_AW-1:0] i_addr,
    input  logic [REG_DW-1:0] i_wdata,
    input  logic              i_spi_sel,
    input  logic              i_efuse_load,
    output logic              o_test_st_reg_en,
    output logic              o_cfg_st_reg_en,
    output logic              o_spi_ctrl_reg_en,
    output logic              o_efuse_ctrl_reg_en
);

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       key_wr;
    logic       in_test;

    // ==================================================
    // key decode
    // ==================================================
    // key address is not gated by any access state
    assign key_wr = i_wen & (i_addr == ADDR_KEY);

    // next state only moves on a key write
    always_comb begin
        state_nxt = state;
        if (key_wr) begin
            case (i_wdata)
                KEY_CFG:  state_nxt = ST_CFG;
                KEY_TEST: state_nxt = ST_TEST;
                // any other value locks the bank again
                default:  state_nxt = ST_IDLE;
            endcase
        end
    end

    // state register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==================================================
    // access enables
    // ==================================================
    assign in_test = (state == ST_TEST);

    assign o_cfg_st_reg_en  = (state == ST_CFG);
    assign o_test_st_reg_en = in_test;

    // external levels pass through
    // but test access stays exclusive
    assign o_spi_ctrl_reg_en   = i_spi_sel    & ~in_test;
    assign o_efuse_ctrl_reg_en = i_efuse_load & ~in_test;

endmodule

// ==== event_capture.sv ====
`timescale 1ns/1ns

module event_capture
    import regbank_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [REG_DW-1:0] i_event,
    output logic [REG_DW-1:0] o_set_pulse
);

    // previous event level per line
    logic [REG_DW-1:0] event_d;
    logic [REG_DW-1:0] pulse_q;

    // events are already in the i_clk domain
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            event_d <= '0;
            pulse_q <= '0;
        end else begin
            event_d <= i_event;
            // one cycle high after the edge that sees the rise
            pulse_q <= i_event & ~event_d;
        end
    end

    assign o_set_pulse = pulse_q;

endmodule

// ==== reg_bank_top.f ====
regbank_pkg.sv
access_state_ctrl.sv
rw_reg.sv
rwc_reg.sv
event_capture.sv
reg_read_combine.sv
reg_bank_top.sv
tb_reg_bank.sv

// ==== reg_bank_top.sv ====
`timescale 1ns/1ns

module reg_bank_top
    import regbank_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wen,
    input  logic              i_ren,
    input  logic [REG_AW-1:0] i_addr,
    input  logic [REG_DW-1:0] i_wdata,
    input  logic              i_spi_sel,
    input  logic              i_efuse_load,
    input  logic [REG_DW-1:0] i_event,
    output logic [REG_DW-1:0] o_rdata,
    output logic              o_irq,
    output logic [REG_DW-1:0] o_ctrl,
    output logic [REG_DW-1:0] o_test_ctrl
);

    // access levels
    logic              test_en;
    logic              cfg_en;
    logic              spi_en;
    logic              efuse_en;
    // per register read data
    logic [REG_DW-1:0] ctrl_rdata;
    logic [REG_DW-1:0] mask_rdata;
    logic [REG_DW-1:0] status_rdata;
    logic [REG_DW-1:0] test_rdata;
    // register contents
    logic [REG_DW-1:0] mask_q;
    logic [REG_DW-1:0] status_q;
    logic [REG_DW-1:0] set_pulse;

    // ==================================================
    // access state
    // ==================================================
    access_state_ctrl u_access (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_wen               (i_wen),
        .i_addr              (i_addr),
        .i_wdata             (i_wdata),
        .i_spi_sel           (i_spi_sel),
        .i_efuse_load        (i_efuse_load),
        .o_test_st_reg_en    (test_en),
        .o_cfg_st_reg_en     (cfg_en),
        .o_spi_ctrl_reg_en   (spi_en),
        .o_efuse_ctrl_reg_en (efuse_en)
    );

    // ==================================================
    // registers
    // ==================================================
    // ctrl, efuse may write but never read
    rw_reg #(
        .REG_ADDR (ADDR_CTRL), .DEFAULT_VAL (CTRL_DEFAULT),
        .SUPPORT_TEST_RD (1'b1), .SUPPORT_CFG_WR (1'b1), .SUPPORT_CFG_RD (1'b1),
        .SUPPORT_SPI_WR (1'b1), .SUPPORT_SPI_RD (1'b1), .SUPPORT_EFUSE_WR (1'b1)
    ) u_ctrl (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_wen (i_wen), .i_ren (i_ren),
        .i_addr (i_addr), .i_wdata (i_wdata),
        .i_test_st_reg_en (test_en), .i_cfg_st_reg_en (cfg_en),
        .i_spi_ctrl_reg_en (spi_en), .i_efuse_ctrl_reg_en (efuse_en),
        .o_rdata (ctrl_rdata), .o_reg_data (o_ctrl)
    );

    // irq mask, test state reads only
    rw_reg #(
        .REG_ADDR (ADDR_IRQ_MASK), .DEFAULT_VAL (IRQ_MASK_DEFAULT),
        .SUPPORT_TEST_RD (1'b1), .SUPPORT_CFG_WR (1'b1), .SUPPORT_CFG_RD (1'b1),
        .SUPPORT_SPI_WR (1'b1), .SUPPORT_SPI_RD (1'b1)
    ) u_irq_mask (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_wen (i_wen), .i_ren (i_ren),
        .i_addr (i_addr), .i_wdata (i_wdata),
        .i_test_st_reg_en (test_en), .i_cfg_st_reg_en (cfg_en),
        .i_spi_ctrl_reg_en (spi_en), .i_efuse_ctrl_reg_en (efuse_en),
        .o_rdata (mask_rdata), .o_reg_data (mask_q)
    );

    // test control, test state only
    rw_reg #(
        .REG_ADDR (ADDR_TEST_CTRL), .DEFAULT_VAL (TEST_CTRL_DEFAULT),
        .SUPPORT_TEST_WR (1'b1), .SUPPORT_TEST_RD (1'b1)
    ) u_test_ctrl (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_wen (i_wen), .i_ren (i_ren),
        .i_addr (i_addr), .i_wdata (i_wdata),
        .i_test_st_reg_en (test_en), .i_cfg_st_reg_en (cfg_en),
        .i_spi_ctrl_reg_en (spi_en), .i_efuse_ctrl_reg_en (efuse_en),
        .o_rdata (test_rdata), .o_reg_data (o_test_ctrl)
    );

    // irq status, set by events, cleared by cpu
    rwc_reg #(
        .REG_ADDR (ADDR_IRQ_STATUS), .DEFAULT_VAL (IRQ_STATUS_DEFAULT),
        .SUPPORT_TEST_WR (1'b1), .SUPPORT_TEST_RD (1'b1), .SUPPORT_CFG_WR (1'b1),
        .SUPPORT_CFG_RD (1'b1), .SUPPORT_SPI_WR (1'b1), .SUPPORT_SPI_RD (1'b1)
    ) u_irq_status (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_wen (i_wen), .i_ren (i_ren),
        .i_addr (i_addr), .i_wdata (i_wdata),
        .i_test_st_reg_en (test_en), .i_cfg_st_reg_en (cfg_en),
        .i_spi_ctrl_reg_en (spi_en), .i_efuse_ctrl_reg_en (efuse_en),
        .i_lgc_wen (set_pulse), .i_lgc_wdata (set_pulse),
        .o_rdata (status_rdata), .o_reg_data (status_q)
    );

    // ==================================================
    // events and read back
    // ==================================================
    event_capture u_event (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_event     (i_event),
        .o_set_pulse (set_pulse)
    );

    reg_read_combine u_read (
        .i_ctrl_rdata   (ctrl_rdata),
        .i_mask_rdata   (mask_rdata),
        .i_status_rdata (status_rdata),
        .i_test_rdata   (test_rdata),
        .i_mask         (mask_q),
        .i_status       (status_q),
        .o_rdata        (o_rdata),
        .o_irq          (o_irq)
    );

endmodule

// ==== reg_read_combine.sv ====
`timescale 1ns/1ns

module reg_read_combine
    import regbank_pkg::*;
(
    input  logic [REG_DW-1:0] i_ctrl_rdata,
    input  logic [REG_DW-1:0] i_mask_rdata,
    input  logic [REG_DW-1:0] i_status_rdata,
    input  logic [REG_DW-1:0] i_test_rdata,
    input  logic [REG_DW-1:0] i_mask,
    input  logic [REG_DW-1:0] i_status,
    output logic [REG_DW-1:0] o_rdata,
    output logic              o_irq
);

    logic [REG_DW-1:0] irq_pending;

    // ==================================================
    // read mux
    // ==================================================
    // unselected registers return zero, so an OR is enough
    // addresses are unique, at most one source is live
    assign o_rdata = i_ctrl_rdata
                   | i_mask_rdata
                   | i_status_rdata
                   | i_test_rdata;

    // ==================================================
    // interrupt
    // ==================================================
    // masked status bits
    assign irq_pending = i_status & i_mask;
    // any pending bit raises the line
    assign o_irq       = |irq_pending;

endmodule

// ==== regbank_pkg.sv ====
package regbank_pkg;

    // ==================================================
    // bus widths
    // ==================================================
    localparam int REG_DW = 8;
    localparam int REG_AW = 8;

    // ==================================================
    // register map
    // ==================================================
    localparam logic [REG_AW-1:0] ADDR_CTRL       = 8'h00;
    localparam logic [REG_AW-1:0] ADDR_IRQ_MASK   = 8'h01;
    localparam logic [REG_AW-1:0] ADDR_IRQ_STATUS = 8'h02;
    // write-only, always writable
    localparam logic [REG_AW-1:0] ADDR_KEY        = 8'h03;
    localparam logic [REG_AW-1:0] ADDR_TEST_CTRL  = 8'h04;

    // unlock values written to ADDR_KEY
    localparam logic [REG_DW-1:0] KEY_CFG  = 8'hA5;
    localparam logic [REG_DW-1:0] KEY_TEST = 8'h5A;

    // ==================================================
    // reset values
    // ==================================================
    localparam logic [REG_DW-1:0] CTRL_DEFAULT       = 8'h01;
    localparam logic [REG_DW-1:0] IRQ_MASK_DEFAULT   = 8'h00;
    localparam logic [REG_DW-1:0] TEST_CTRL_DEFAULT  = 8'h00;
    localparam logic [REG_DW-1:0] IRQ_STATUS_DEFAULT = 8'h00;

    // access fsm encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CFG  = 2'd1;
    localparam logic [1:0] ST_TEST = 2'd2;

endpackage

// ==== rw_reg.sv ====
`timescale 1ns/1ns

module rw_reg
    import regbank_pkg::*;
#(
    parameter logic [REG_AW-1:0] REG_ADDR    = '0,
    parameter logic [REG_DW-1:0] DEFAULT_VAL = '0,
    parameter bit SUPPORT_TEST_WR  = 1'b0,
    parameter bit SUPPORT_TEST_RD  = 1'b0,
    parameter bit SUPPORT_CFG_WR   = 1'b0,
    parameter bit SUPPORT_CFG_RD   = 1'b0,
    parameter bit SUPPORT_SPI_WR   = 1'b0,
    parameter bit SUPPORT_SPI_RD   = 1'b0,
    parameter bit SUPPORT_EFUSE_WR = 1'b0,
    parameter bit SUPPORT_EFUSE_RD = 1'b0
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wen,
    input  logic              i_ren,
    input  logic [REG_AW-1:0] i_addr,
    input  logic [REG_DW-1:0] i_wdata,
    input  logic              i_test_st_reg_en,
    input  logic              i_cfg_st_reg_en,
    input  logic              i_spi_ctrl_reg_en,
    input  logic              i_efuse_ctrl_reg_en,
    output logic [REG_DW-1:0] o_rdata,
    output logic [REG_DW-1:0] o_reg_data
);

    logic              hit;
    logic              wr_ok;
    logic              rd_ok;
    logic [REG_DW-1:0] reg_data;

    assign hit = (i_addr == REG_ADDR);

    // any active state that this register supports opens the access
    assign wr_ok = (i_test_st_reg_en    & SUPPORT_TEST_WR)
                 | (i_cfg_st_reg_en     & SUPPORT_CFG_WR)
                 | (i_spi_ctrl_reg_en   & SUPPORT_SPI_WR)
                 | (i_efuse_ctrl_reg_en & SUPPORT_EFUSE_WR);
    assign rd_ok = (i_test_st_reg_en    & SUPPORT_TEST_RD)
                 | (i_cfg_st_reg_en     & SUPPORT_CFG_RD)
                 | (i_spi_ctrl_reg_en   & SUPPORT_SPI_RD)
                 | (i_efuse_ctrl_reg_en & SUPPORT_EFUSE_RD);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reg_data <= DEFAULT_VAL;
        end else if (i_wen && hit && wr_ok) begin
            reg_data <= i_wdata;
        end
    end

    assign o_reg_data = reg_data;
    // zero keeps the read-data OR tree clean
    assign o_rdata    = (i_ren & hit & rd_ok) ? reg_data : '0;

endmodule

// ==== rwc_reg.sv ====
`timescale 1ns/1ns

module rwc_reg
    import regbank_pkg::*;
#(
    parameter logic [REG_AW-1:0] REG_ADDR    = '0,
    parameter logic [REG_DW-1:0] DEFAULT_VAL = '0,
    parameter bit SUPPORT_TEST_WR  = 1'b0,
    parameter bit SUPPORT_TEST_RD  = 1'b0,
    parameter bit SUPPORT_CFG_WR   = 1'b0,
    parameter bit SUPPORT_CFG_RD   = 1'b0,
    parameter bit SUPPORT_SPI_WR   = 1'b0,
    parameter bit SUPPORT_SPI_RD   = 1'b0,
    parameter bit SUPPORT_EFUSE_WR = 1'b0,
    parameter bit SUPPORT_EFUSE_RD = 1'b0
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wen,
    input  logic              i_ren,
    input  logic [REG_AW-1:0] i_addr,
    input  logic [REG_DW-1:0] i_wdata,
    input  logic              i_test_st_reg_en,
    input  logic              i_cfg_st_reg_en,
    input  logic              i_spi_ctrl_reg_en,
    input  logic              i_efuse_ctrl_reg_en,
    input  logic [REG_DW-1:0] i_lgc_wen,
    input  logic [REG_DW-1:0] i_lgc_wdata,
    output logic [REG_DW-1:0] o_rdata,
    output logic [REG_DW-1:0] o_reg_data
);

    logic              hit;
    logic              wen;
    logic              ren;
    logic [REG_DW-1:0] clr_bits;
    logic [REG_DW-1:0] set_bits;
    logic [REG_DW-1:0] reg_data;

    assign hit = (i_addr == REG_ADDR);
    assign wen = i_wen & hit & ((i_test_st_reg_en    & SUPPORT_TEST_WR)
                              | (i_cfg_st_reg_en     & SUPPORT_CFG_WR)
                              | (i_spi_ctrl_reg_en   & SUPPORT_SPI_WR)
                              | (i_efuse_ctrl_reg_en & SUPPORT_EFUSE_WR));
    assign ren = i_ren & hit & ((i_test_st_reg_en    & SUPPORT_TEST_RD)
                              | (i_cfg_st_reg_en     & SUPPORT_CFG_RD)
                              | (i_spi_ctrl_reg_en   & SUPPORT_SPI_RD)
                              | (i_efuse_ctrl_reg_en & SUPPORT_EFUSE_RD));

    // write one to clear, per bit
    assign clr_bits = wen ? i_wdata : '0;
    // inner logic sets where both enable and data are high
    assign set_bits = i_lgc_wen & i_lgc_wdata;

    // clear wins over a set in the same cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reg_data <= DEFAULT_VAL;
        end else begin
            reg_data <= (reg_data | set_bits) & ~clr_bits;
        end
    end

    assign o_reg_data = reg_data;
    assign o_rdata    = ren ? reg_data : '0;

endmodule

// ==== tb_reg_bank.sv ====
`timescale 1ns/1ns

module tb_reg_bank
    import regbank_pkg::*;
;

    localparam int CLK_PERIOD = 100;
    // cycles per test in run order
    localparam int TEST_CYCLES = 5 + 14 + 42 + 18 + 24 + 20 + 20;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_wen;
    logic              i_ren;
    logic [REG_AW-1:0] i_addr;
    logic [REG_DW-1:0] i_wdata;
    logic              i_spi_sel;
    logic              i_efuse_load;
    logic [REG_DW-1:0] i_event;
    logic [REG_DW-1:0] o_rdata;
    logic              o_irq;
    logic [REG_DW-1:0] o_ctrl;
    logic [REG_DW-1:0] o_test_ctrl;

    // expected register contents
    logic [REG_DW-1:0] exp_ctrl;
    logic [REG_DW-1:0] exp_mask;
    logic [REG_DW-1:0] exp_test;
    logic [REG_DW-1:0] exp_status;
    logic [31:0]       lcg_state;

    reg_bank_top UUT (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wen        (i_wen),
        .i_ren        (i_ren),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_spi_sel    (i_spi_sel),
        .i_efuse_load (i_efuse_load),
        .i_event      (i_event),
        .o_rdata      (o_rdata),
        .o_irq        (o_irq),
        .o_ctrl       (o_ctrl),
        .o_test_ctrl  (o_test_ctrl)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD/2) i_clk = ~i_clk;
    end

    // watchdog at twice the expected run length
    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        $display("Simulation failed");
        $fatal(1);
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [REG_DW-1:0] v);
        lcg_state = lcg_step(lcg_state);
        // upper bits of the lcg are the better ones
        v = lcg_state[23:16];
    endtask

    task automatic check_value(input string name, input logic [REG_DW-1:0] got,
                               input logic [REG_DW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // one-cycle write strobe then wait for the falling edge
    task automatic write_reg(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
        @(posedge i_clk);
        i_wen   <= 1'b1;
        i_addr  <= addr;
        i_wdata <= data;
        @(posedge i_clk);
        i_wen <= 1'b0;
        @(negedge i_clk);
    endtask

    // read data is combinational so sample mid-cycle
    task automatic read_reg(input logic [REG_AW-1:0] addr, output logic [REG_DW-1:0] data);
        @(posedge i_clk);
        i_ren  <= 1'b1;
        i_addr <= addr;
        @(negedge i_clk);
        data = o_rdata;
        @(posedge i_clk);
        i_ren <= 1'b0;
        @(negedge i_clk);
    endtask

    task automatic read_check(input string name, input logic [REG_AW-1:0] addr,
                              input logic [REG_DW-1:0] exp);
        logic [REG_DW-1:0] data;
        read_reg(addr, data);
        check_value(name, data, exp);
    endtask

    task automatic set_levels(input logic spi, input logic efuse);
        @(posedge i_clk);
        i_spi_sel    <= spi;
        i_efuse_load <= efuse;
        @(negedge i_clk);
    endtask

    // single-cycle high on the given event lines
    task automatic pulse_events(input logic [REG_DW-1:0] bits);
        @(posedge i_clk);
        i_event <= bits;
        @(posedge i_clk);
        i_event <= '0;
        @(negedge i_clk);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i_clk);
        @(negedge i_clk);
    endtask

    task automatic check_irq();
        check_value("o_irq", {7'd0, o_irq}, {7'd0, |(exp_status & exp_mask)});
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_reset_defaults();
        check_value("o_ctrl", o_ctrl, CTRL_DEFAULT);
        check_value("o_test_ctrl", o_test_ctrl, TEST_CTRL_DEFAULT);
        check_irq();
        // nothing is writable in idle
        write_reg(ADDR_CTRL, ~CTRL_DEFAULT);
        check_value("o_ctrl", o_ctrl, exp_ctrl);
        for (int a = 0; a < 5; a++) begin
            read_check("o_rdata idle", a[REG_AW-1:0], '0);
        end
    endtask

    task automatic test_cfg_state();
        logic [REG_DW-1:0] v;
        write_reg(ADDR_KEY, KEY_CFG);
        for (int i = 0; i < 4; i++) begin
            next_rand(v);
            write_reg(ADDR_CTRL, v);
            exp_ctrl = v;
            check_value("o_ctrl", o_ctrl, exp_ctrl);
            read_check("o_rdata ctrl", ADDR_CTRL, exp_ctrl);
            next_rand(v);
            write_reg(ADDR_IRQ_MASK, v);
            exp_mask = v;
            read_check("o_rdata irq_mask", ADDR_IRQ_MASK, exp_mask);
        end
        // test control stays locked in cfg
        write_reg(ADDR_TEST_CTRL, 8'h3c);
        check_value("o_test_ctrl", o_test_ctrl, exp_test);
        read_check("o_rdata test_ctrl", ADDR_TEST_CTRL, '0);
        write_reg(ADDR_KEY, 8'h00);
    endtask

    task automatic test_test_state();
        logic [REG_DW-1:0] v;
        write_reg(ADDR_KEY, KEY_TEST);
        next_rand(v);
        write_reg(ADDR_TEST_CTRL, v);
        exp_test = v;
        check_value("o_test_ctrl", o_test_ctrl, exp_test);
        read_check("o_rdata test_ctrl", ADDR_TEST_CTRL, exp_test);
        // spi select is masked in test
        set_levels(1'b1, 1'b0);
        write_reg(ADDR_CTRL, ~exp_ctrl);
        check_value("o_ctrl", o_ctrl, exp_ctrl);
        read_check("o_rdata ctrl", ADDR_CTRL, exp_ctrl);
        set_levels(1'b0, 1'b0);
        // non-key value drops back to idle
        write_reg(ADDR_KEY, 8'h00);
        read_check("o_rdata test_ctrl", ADDR_TEST_CTRL, '0);
        check_value("o_test_ctrl", o_test_ctrl, exp_test);
    endtask

    task automatic test_irq_status();
        write_reg(ADDR_KEY, KEY_CFG);
        // only bit 4 unmasked so o_irq can drop while status is nonzero
        write_reg(ADDR_IRQ_MASK, 8'h10);
        exp_mask = 8'h10;
        pulse_events(8'h12);
        pulse_events(8'h40);
        wait_cycles(3);
        exp_status = 8'h12 | 8'h40;
        read_check("o_rdata irq_status", ADDR_IRQ_STATUS, exp_status);
        check_irq();
        // write one clears only those bits
        write_reg(ADDR_IRQ_STATUS, 8'h10);
        exp_status = exp_status & ~8'h10;
        read_check("o_rdata irq_status", ADDR_IRQ_STATUS, exp_status);
        check_irq();
        write_reg(ADDR_IRQ_STATUS, 8'h42);
        exp_status = '0;
        read_check("o_rdata irq_status", ADDR_IRQ_STATUS, exp_status);
        check_irq();
    endtask

    task automatic test_clear_priority();
        pulse_events(8'h01);
        wait_cycles(2);
        exp_status = 8'h01;
        // bit 1 rises a cycle early so its set pulse meets the clear
        @(posedge i_clk);
        i_event <= 8'h02;
        // bit 0 rises with the clear and its pulse lands one edge later
        @(posedge i_clk);
        i_wen   <= 1'b1;
        i_addr  <= ADDR_IRQ_STATUS;
        i_wdata <= 8'h03;
        i_event <= 8'h03;
        @(posedge i_clk);
        i_wen   <= 1'b0;
        i_event <= '0;
        wait_cycles(2);
        exp_status = 8'h01;
        read_check("o_rdata irq_status", ADDR_IRQ_STATUS, exp_status);
        check_irq();
        write_reg(ADDR_IRQ_STATUS, 8'h01);
        exp_status = '0;
        write_reg(ADDR_KEY, 8'h00);
    endtask

    task automatic test_spi_efuse();
        logic [REG_DW-1:0] v;
        set_levels(1'b1, 1'b0);
        next_rand(v);
        write_reg(ADDR_CTRL, v);
        exp_ctrl = v;
        read_check("o_rdata ctrl", ADDR_CTRL, exp_ctrl);
        next_rand(v);
        write_reg(ADDR_IRQ_MASK, v);
        exp_mask = v;
        read_check("o_rdata irq_mask", ADDR_IRQ_MASK, exp_mask);
        // efuse load writes ctrl but reads nothing
        set_levels(1'b0, 1'b1);
        next_rand(v);
        write_reg(ADDR_CTRL, v);
        exp_ctrl = v;
        check_value("o_ctrl", o_ctrl, exp_ctrl);
        read_check("o_rdata ctrl", ADDR_CTRL, '0);
        read_check("o_rdata irq_mask", ADDR_IRQ_MASK, '0);
        set_levels(1'b0, 1'b0);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        i_rst_n      = 1'b0;
        i_wen        = 1'b0;
        i_ren        = 1'b0;
        i_addr       = '0;
        i_wdata      = '0;
        i_spi_sel    = 1'b0;
        i_efuse_load = 1'b0;
        i_event      = '0;
        lcg_state    = 32'h3cfd_46c0;
        exp_ctrl     = CTRL_DEFAULT;
        exp_mask     = IRQ_MASK_DEFAULT;
        exp_test     = TEST_CTRL_DEFAULT;
        exp_status   = IRQ_STATUS_DEFAULT;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        test_reset_defaults();
        test_cfg_state();
        test_test_state();
        test_irq_status();
        test_clear_priority();
        test_spi_efuse();
        $display("Simulation passed");
        $finish;
    end

endmodule
